// ==== source/sms_pkg.sv ====
// Shared constants, types and download decode helpers, referenced by scoped name from every block
package sms_pkg;

	// ==================================================
	// Widths and sizes
	// ==================================================
	localparam int ROM_ADDR_W   = 22;
	localparam int DL_ADDR_W    = 25; // Host download byte address
	localparam int BYTE_W       = 8;
	localparam int LBA_W        = 32;
	localparam logic [ROM_ADDR_W-1:0] HEADER_BYTES = ROM_ADDR_W'(512); // Copier header

	localparam int SECTOR_BYTES = 512;
	localparam int BK_SECTORS   = 4;
	localparam int BUFF_ADDR_W  = $clog2(SECTOR_BYTES);
	localparam int SECTOR_SEL_W = $clog2(BK_SECTORS);
	localparam int NVRAM_ADDR_W = $clog2(BK_SECTORS * SECTOR_BYTES);

	localparam int CE_PERIOD    = 30; // Master clocks per divider frame

	// Download index codes
	localparam logic [BYTE_W-1:0] CHEAT_INDEX = '1;
	localparam logic [4:0]        GG_INDEX    = 5'd2; // Handheld cartridge

	// ==================================================
	// Types
	// ==================================================
	typedef enum logic [1:0] {
		idle,
		load_wait,
		save_wait,
		next_sector
	} bk_state_e;

	// Flags in the top word, replace value in the bottom word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	function automatic logic is_cheat_dl(input logic active, input logic [BYTE_W-1:0] index);
		return active && (index == CHEAT_INDEX);
	endfunction

	function automatic logic is_cart_dl(input logic active, input logic [BYTE_W-1:0] index);
		return active && (index != CHEAT_INDEX);
	endfunction

endpackage

// ==== source/sms_ifs.sv ====
// Download bus and backup sector port bundles passed between the host glue modules
`timescale 1ns/1ns

// ==================================================
// Host download stream
// ==================================================
interface dl_if;
	logic                            active; // Download in progress
	logic [sms_pkg::BYTE_W-1:0]      index;  // File type selector
	logic                            wr;     // One-cycle byte strobe
	logic [sms_pkg::DL_ADDR_W-1:0]   addr;
	logic [sms_pkg::BYTE_W-1:0]      data;

	modport sink (
		input active,
		input index,
		input wr,
		input addr,
		input data
	);
endinterface

// ==================================================
// Backup sector port
// ==================================================
interface sector_if;
	logic [sms_pkg::LBA_W-1:0]       lba;
	logic                            rd;
	logic                            wr;
	logic                            ack;       // High for the whole sector burst
	logic [sms_pkg::BUFF_ADDR_W-1:0] buff_addr;
	logic                            buff_wr;
	logic [sms_pkg::BYTE_W-1:0]      buff_dout; // Host to buffer
	logic [sms_pkg::BYTE_W-1:0]      buff_din;  // Buffer to host

	modport ctrl (output lba, output rd, output wr, input ack);

	modport ram (
		input  lba,
		input  buff_addr,
		input  buff_wr,
		input  buff_dout,
		input  ack,
		output buff_din
	);
endinterface

// ==== source/clock_enable_gen.sv ====
// Divides clk_sys over a 30-phase frame into the CPU, VDP, pixel and sound clock enables
`timescale 1ns/1ns

module clock_enable_gen (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	logic [$clog2(sms_pkg::CE_PERIOD)-1:0] phase;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase  <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			if (int'(phase) == sms_pkg::CE_PERIOD - 1)
				phase <= '0;
			else
				phase <= phase + 1'b1;

			ce_sp  <= phase[0]; // High on odd phases
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			case (phase)
				5'd4, 5'd14: ce_vdp <= 1'b1;
				5'd9: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				5'd19, 5'd29: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				5'd24: begin
					ce_cpu <= 1'b1; // Late CPU slot keeps the VDP H counter aligned
					ce_vdp <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== source/cart_loader.sv ====
// Writes downloaded cartridge bytes to ROM memory and maps console ROM reads through the size mask
`timescale 1ns/1ns

module cart_loader (
	input  logic                             clk_sys,
	input  logic                             reset,
	dl_if.sink                               dl,
	output logic                             dl_wait,
	output logic                             rom_req,
	input  logic                             rom_ack,
	output logic [sms_pkg::ROM_ADDR_W-1:0]   rom_waddr,
	output logic [sms_pkg::BYTE_W-1:0]       rom_wdata,
	input  logic [sms_pkg::ROM_ADDR_W-1:0]   cpu_rom_addr,
	output logic [sms_pkg::ROM_ADDR_W-1:0]   rom_raddr,
	output logic                             gg_mode
);

	logic                            cart_dl;
	logic                            old_cart_dl;
	logic                            cart_byte;
	logic                            rom_done;
	logic [sms_pkg::ROM_ADDR_W-1:0]  byte_addr;
	logic [sms_pkg::ROM_ADDR_W-1:0]  cart_mask;
	logic [sms_pkg::ROM_ADDR_W-1:0]  mask512;
	logic [sms_pkg::DL_ADDR_W-1:0]   dl_end; // One past the last byte, the image size
	logic                            sz512;

	assign cart_dl   = sms_pkg::is_cart_dl(dl.active, dl.index);
	assign cart_byte = cart_dl && dl.wr;
	assign byte_addr = dl.addr[sms_pkg::ROM_ADDR_W-1:0];
	assign rom_done  = dl_wait && (rom_req == rom_ack); // Memory caught up with the toggle

	// ==================================================
	// ROM write handshake
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart_dl <= 1'b0;
			dl_wait     <= 1'b0;
			rom_req     <= 1'b0;
			rom_waddr   <= '0;
		end else begin
			old_cart_dl <= cart_dl;
			if (cart_byte) begin
				rom_req <= ~rom_req;
				dl_wait <= 1'b1; // Host holds off until the write lands
			end else if (rom_done) begin
				dl_wait <= 1'b0;
			end

			if (cart_dl && !old_cart_dl)
				rom_waddr <= '0;
			else if (rom_done)
				rom_waddr <= rom_waddr + 1'b1;
		end
	end

	// Byte payload and size masks
	always_ff @(posedge clk_sys) begin
		if (cart_byte) begin
			rom_wdata <= dl.data;
			dl_end    <= dl.addr + 1;
			cart_mask <= (byte_addr == '0) ? '0 : (cart_mask | byte_addr);
			mask512   <= (byte_addr == sms_pkg::HEADER_BYTES) ? '0 :
			             (mask512 | (byte_addr - sms_pkg::HEADER_BYTES));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sz512   <= 1'b0;
			gg_mode <= 1'b0;
		end else begin
			if (cart_byte)
				gg_mode <= (dl.index[4:0] == sms_pkg::GG_INDEX);
			if (old_cart_dl && !cart_dl)
				sz512 <= dl_end[9]; // Odd half-KiB size means a copier header
		end
	end

	// CPU address translation
	assign rom_raddr = sz512 ? ((cpu_rom_addr + sms_pkg::HEADER_BYTES) & mask512) :
	                           (cpu_rom_addr & cart_mask);

	// Host must respect back-pressure
	a_no_byte_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wait |-> !cart_byte);

endmodule

// ==== source/cheat_loader.sv ====
// Builds 16-byte cheat records from the cheat download stream and flags each completed record
`timescale 1ns/1ns

module cheat_loader (
	input  logic                 clk_sys,
	input  logic                 reset,
	dl_if.sink                   dl,
	output sms_pkg::cheat_code_t cheat_code,
	output logic                 code_valid
);

	logic                        cheat_byte;
	logic [4:0]                  bit_ofs; // Byte lane within the 32-bit field

	assign cheat_byte = sms_pkg::is_cheat_dl(dl.active, dl.index) && dl.wr;
	assign bit_ofs    = {dl.addr[1:0], 3'b000};

	// Four fields of four bytes, least significant byte first
	always_ff @(posedge clk_sys) begin
		if (cheat_byte) begin
			case (dl.addr[3:2])
				2'd0: cheat_code.flags[bit_ofs +: sms_pkg::BYTE_W]   <= dl.data;
				2'd1: cheat_code.address[bit_ofs +: sms_pkg::BYTE_W] <= dl.data;
				2'd2: cheat_code.compare[bit_ofs +: sms_pkg::BYTE_W] <= dl.data;
				2'd3: cheat_code.replace[bit_ofs +: sms_pkg::BYTE_W] <= dl.data;
				default: ;
			endcase
		end
	end

	// ==================================================
	// Record complete strobe
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= cheat_byte && (dl.addr[3:0] == 4'hf); // Last byte of record
	end

endmodule

// ==== source/backup_ram.sv ====
// Dual-port backup RAM shared by the console save port and the host sector buffer
`timescale 1ns/1ns

module backup_ram (
	input  logic                               clk_sys,
	input  logic [sms_pkg::NVRAM_ADDR_W-1:0]   nvram_addr,
	input  logic                               nvram_we,
	input  logic [sms_pkg::BYTE_W-1:0]         nvram_wdata,
	output logic [sms_pkg::BYTE_W-1:0]         nvram_rdata,
	sector_if.ram                              sec
);

	logic [sms_pkg::BYTE_W-1:0]       mem [sms_pkg::BK_SECTORS * sms_pkg::SECTOR_BYTES];
	logic [sms_pkg::NVRAM_ADDR_W-1:0] sec_addr;

	// Sector select on top, byte within sector below
	assign sec_addr = {sec.lba[sms_pkg::SECTOR_SEL_W-1:0], sec.buff_addr};

	// Console port
	always @(posedge clk_sys) begin
		if (nvram_we)
			mem[nvram_addr] <= nvram_wdata;
		nvram_rdata <= mem[nvram_addr];
	end

	// Host buffer port, writes only inside an ack burst
	always @(posedge clk_sys) begin
		if (sec.buff_wr && sec.ack)
			mem[sec_addr] <= sec.buff_dout;
		sec.buff_din <= mem[sec_addr];
	end

endmodule

// ==== source/bk_controller.sv ====
// Sequences backup RAM load and save sector by sector and merges the console reset sources
`timescale 1ns/1ns

module bk_controller (
	input  logic   clk_sys,
	input  logic   reset,
	dl_if.sink     dl,
	sector_if.ctrl sec,
	input  logic   img_mounted,
	input  logic   img_readonly,
	input  logic   img_size_nz,
	input  logic   bk_load,
	input  logic   bk_save,
	input  logic   autosave,
	input  logic   osd_open,
	input  logic   nvram_we,
	output logic   core_reset,
	output logic   bk_busy
);

	sms_pkg::bk_state_e state;
	logic cart_dl;
	logic old_cart_dl;
	logic dl_done;
	logic bk_ena;    // Writable save image present
	logic pending;   // Console wrote since the last save
	logic loading;
	logic save_req;
	logic old_load;
	logic old_save;
	logic load_start;
	logic save_start;
	logic old_ack;
	logic ack_rise;
	logic ack_fall;

	assign cart_dl  = sms_pkg::is_cart_dl(dl.active, dl.index);
	assign dl_done  = old_cart_dl && !cart_dl;
	assign save_req = bk_save || (pending && osd_open && autosave); // Autosave on menu open
	assign ack_rise = sec.ack && !old_ack;
	assign ack_fall = !sec.ack && old_ack;

	assign load_start = (state == sms_pkg::idle) && bk_ena &&
	                    ((bk_load && !old_load) || (dl_done && img_size_nz));
	assign save_start = (state == sms_pkg::idle) && bk_ena && save_req && !old_save &&
	                    !load_start;

	// ==================================================
	// Enable, pending and edge tracking
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart_dl <= 1'b0;
			old_load    <= 1'b0;
			old_save    <= 1'b0;
			old_ack     <= 1'b0;
			bk_ena      <= 1'b0;
			pending     <= 1'b0;
		end else begin
			old_cart_dl <= cart_dl;
			old_load    <= bk_load;
			old_save    <= save_req;
			old_ack     <= sec.ack;

			if (cart_dl && !old_cart_dl)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1; // Save image mounts during the cart download

			if (save_start)
				pending <= 1'b0;
			else if (bk_ena && !osd_open && nvram_we)
				pending <= 1'b1;
		end
	end

	// ==================================================
	// Sector sequencer
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= sms_pkg::idle;
			loading <= 1'b0;
			sec.lba <= '0;
			sec.rd  <= 1'b0;
			sec.wr  <= 1'b0;
		end else begin
			if (ack_rise) begin // Host took the request
				sec.rd <= 1'b0;
				sec.wr <= 1'b0;
			end

			case (state)
				sms_pkg::idle: begin
					if (load_start) begin
						state   <= sms_pkg::load_wait;
						loading <= 1'b1;
						sec.lba <= '0;
						sec.rd  <= 1'b1;
					end else if (save_start) begin
						state   <= sms_pkg::save_wait;
						loading <= 1'b0;
						sec.lba <= '0;
						sec.wr  <= 1'b1;
					end
				end
				sms_pkg::load_wait, sms_pkg::save_wait: begin
					if (ack_fall)
						state <= sms_pkg::next_sector; // Burst over
				end
				sms_pkg::next_sector: begin
					if (sec.lba == sms_pkg::BK_SECTORS - 1) begin
						state   <= sms_pkg::idle;
						loading <= 1'b0;
					end else begin
						sec.lba <= sec.lba + 1;
						sec.rd  <= loading;
						sec.wr  <= !loading;
						state   <= loading ? sms_pkg::load_wait : sms_pkg::save_wait;
					end
				end
				default: state <= sms_pkg::idle;
			endcase
		end
	end

	assign bk_busy    = (state != sms_pkg::idle);
	assign core_reset = reset || cart_dl || loading; // Console held while memory changes

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sec.rd && sec.wr));

endmodule

// ==== source/sms_host_top.sv ====
// Top level of the host glue, wiring plain host and console ports to the loader and backup blocks
`timescale 1ns/1ns

module sms_host_top (
	input  logic                               clk_sys,
	input  logic                               reset,
	// Clock enables
	output logic                               ce_cpu,
	output logic                               ce_vdp,
	output logic                               ce_pix,
	output logic                               ce_sp,
	// Host download
	input  logic                               dl_active,
	input  logic [sms_pkg::BYTE_W-1:0]         dl_index,
	input  logic                               dl_wr,
	input  logic [sms_pkg::DL_ADDR_W-1:0]      dl_addr,
	input  logic [sms_pkg::BYTE_W-1:0]         dl_data,
	output logic                               dl_wait,
	// ROM memory
	output logic                               rom_req,
	input  logic                               rom_ack,
	output logic [sms_pkg::ROM_ADDR_W-1:0]     rom_waddr,
	output logic [sms_pkg::BYTE_W-1:0]         rom_wdata,
	input  logic [sms_pkg::ROM_ADDR_W-1:0]     cpu_rom_addr,
	output logic [sms_pkg::ROM_ADDR_W-1:0]     rom_raddr,
	output logic                               gg_mode,
	// Cheats
	output sms_pkg::cheat_code_t               cheat_code,
	output logic                               code_valid,
	// Console save port
	input  logic [sms_pkg::NVRAM_ADDR_W-1:0]   nvram_addr,
	input  logic                               nvram_we,
	input  logic [sms_pkg::BYTE_W-1:0]         nvram_wdata,
	output logic [sms_pkg::BYTE_W-1:0]         nvram_rdata,
	// Host sector port
	output logic [sms_pkg::LBA_W-1:0]          sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	input  logic                               sd_ack,
	input  logic [sms_pkg::BUFF_ADDR_W-1:0]    sd_buff_addr,
	input  logic                               sd_buff_wr,
	input  logic [sms_pkg::BYTE_W-1:0]         sd_buff_dout,
	output logic [sms_pkg::BYTE_W-1:0]         sd_buff_din,
	// Save image and menu
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic                               img_size_nz,
	input  logic                               bk_load,
	input  logic                               bk_save,
	input  logic                               autosave,
	input  logic                               osd_open,
	output logic                               core_reset,
	output logic                               bk_busy
);

	dl_if     dl_bus ();
	sector_if sec_bus ();

	assign dl_bus.active = dl_active;
	assign dl_bus.index  = dl_index;
	assign dl_bus.wr     = dl_wr;
	assign dl_bus.addr   = dl_addr;
	assign dl_bus.data   = dl_data;

	assign sec_bus.ack       = sd_ack;
	assign sec_bus.buff_addr = sd_buff_addr;
	assign sec_bus.buff_wr   = sd_buff_wr;
	assign sec_bus.buff_dout = sd_buff_dout;
	assign sd_lba            = sec_bus.lba;
	assign sd_rd             = sec_bus.rd;
	assign sd_wr             = sec_bus.wr;
	assign sd_buff_din       = sec_bus.buff_din;

	clock_enable_gen u_ce (.clk_sys, .reset, .ce_cpu, .ce_vdp, .ce_pix, .ce_sp);

	cart_loader u_cart (
		.clk_sys, .reset, .dl(dl_bus.sink), .dl_wait, .rom_req, .rom_ack,
		.rom_waddr, .rom_wdata, .cpu_rom_addr, .rom_raddr, .gg_mode
	);

	cheat_loader u_cheat (.clk_sys, .reset, .dl(dl_bus.sink), .cheat_code, .code_valid);

	backup_ram u_bram (
		.clk_sys, .nvram_addr, .nvram_we, .nvram_wdata, .nvram_rdata, .sec(sec_bus.ram)
	);

	bk_controller u_bk (
		.clk_sys, .reset, .dl(dl_bus.sink), .sec(sec_bus.ctrl),
		.img_mounted, .img_readonly, .img_size_nz, .bk_load, .bk_save,
		.autosave, .osd_open, .nvram_we, .core_reset, .bk_busy
	);

endmodule

// ==== dv/tb_sms_host.sv ====
// Testbench for the host glue top level, with ROM and sector host models; built from the file list
`timescale 1ns/1ns

module tb_sms_host;

	localparam int ROM_W     = sms_pkg::ROM_ADDR_W;
	localparam int DL_W      = sms_pkg::DL_ADDR_W;
	localparam int NV_W      = sms_pkg::NVRAM_ADDR_W;
	localparam int BUF_W     = sms_pkg::BUFF_ADDR_W;
	localparam int SECTOR    = sms_pkg::SECTOR_BYTES;
	localparam int NV_BYTES  = sms_pkg::BK_SECTORS * sms_pkg::SECTOR_BYTES;
	localparam int CART_LEN  = 16384;
	localparam int HDR_LEN   = 512 + 8192;
	localparam int GG_LEN    = 64;
	localparam int SMALL_LEN = 32;
	localparam int BYTE_CYCLES = 7; // Worst case per cart byte with a 3-cycle ROM
	localparam int WATCHDOG_CYCLES =
		BYTE_CYCLES * (CART_LEN + HDR_LEN + GG_LEN + 2 * SMALL_LEN + 16) +
		3 * sms_pkg::BK_SECTORS * (SECTOR + 16) + 4 * NV_BYTES + 2000;

	logic clk_sys = 1'b0;
	logic reset;
	logic ce_cpu, ce_vdp, ce_pix, ce_sp;
	logic dl_active, dl_wr, dl_wait;
	logic [7:0] dl_index, dl_data;
	logic [DL_W-1:0] dl_addr;
	logic rom_req, rom_ack, gg_mode;
	logic [ROM_W-1:0] rom_waddr, cpu_rom_addr, rom_raddr;
	logic [7:0] rom_wdata;
	sms_pkg::cheat_code_t cheat_code;
	logic code_valid;
	logic [NV_W-1:0] nvram_addr;
	logic nvram_we;
	logic [7:0] nvram_wdata, nvram_rdata;
	logic [31:0] sd_lba;
	logic sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [BUF_W-1:0] sd_buff_addr;
	logic [7:0] sd_buff_dout, sd_buff_din;
	logic img_mounted, img_readonly, img_size_nz;
	logic bk_load, bk_save, autosave, osd_open;
	logic core_reset, bk_busy;

	// Testbench state
	logic [15:0] data_lfsr = 16'd60;
	logic [15:0] delay_lfsr = 16'd60; // Separate stream for model latencies
	logic [7:0]  file_data [CART_LEN];
	logic [7:0]  bram_model [NV_BYTES];
	logic [7:0]  load_data [NV_BYTES];
	logic [ROM_W-1:0] ref_mask;
	logic ref_hdr;
	logic raddr_on = 1'b0;
	logic expect_save;
	int rom_count;
	int sectors_seen;
	int valid_count;
	int errors = 0;
	int errors_mark = 0;
	int test_num = 0;
	int failed_tests = 0;

	sms_host_top dut (.*);

	always #10 clk_sys = ~clk_sys;

	// ==================================================
	// Helpers and reference functions
	// ==================================================
	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v = {v[30:0], st[0]};
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// Enables seen k cycles after the first ce_vdp, which comes from phase 4
	function automatic logic [3:0] expected_ce(input int k);
		int p;
		p = (k + 4) % sms_pkg::CE_PERIOD;
		return {p == 9 || p == 24, p % 5 == 4, p % 10 == 9, p % 2 == 1};
	endfunction

	// Odd count of 512-byte blocks means a copier header
	function automatic logic has_header(input int len);
		return ((len >> 9) & 1) == 1;
	endfunction

	function automatic logic [ROM_W-1:0] expected_mask(input int len, input logic hdr);
		logic [ROM_W-1:0] m;
		int base;
		base = hdr ? 512 : 0;
		m = '0;
		for (int a = base; a < len; a++)
			m = m | ROM_W'(a - base);
		return m;
	endfunction

	function automatic logic [ROM_W-1:0] expected_raddr(input logic [ROM_W-1:0] cpu,
		input logic [ROM_W-1:0] mask, input logic hdr);
		return hdr ? ((cpu + ROM_W'(512)) & mask) : (cpu & mask);
	endfunction

	function automatic sms_pkg::cheat_code_t expected_cheat();
		sms_pkg::cheat_code_t c;
		c.flags   = {file_data[3], file_data[2], file_data[1], file_data[0]};
		c.address = {file_data[7], file_data[6], file_data[5], file_data[4]};
		c.compare = {file_data[11], file_data[10], file_data[9], file_data[8]};
		c.replace = {file_data[15], file_data[14], file_data[13], file_data[12]};
		return c;
	endfunction

	task automatic fill_file(input int len);
		logic [31:0] r;
		for (int a = 0; a < len; a++) begin
			random_bits(data_lfsr, 8, r);
			file_data[a] = r[7:0];
		end
	endtask

	// Host side of a download that honors dl_wait after every byte
	task automatic send_file(input logic [7:0] index, input int len);
		rom_count = 0;
		dl_index  = index;
		dl_active = 1'b1;
		next_cycle();
		for (int a = 0; a < len; a++) begin
			dl_wr   = 1'b1;
			dl_addr = DL_W'(a);
			dl_data = file_data[a];
			next_cycle();
			dl_wr = 1'b0;
			if (index != sms_pkg::CHEAT_INDEX)
				check(dl_wait, $sformatf("dl_wait low in the cycle after cart byte %0d", a));
			while (dl_wait)
				next_cycle();
		end
		dl_active = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic sweep_rom_reads(input logic [ROM_W-1:0] mask, input logic hdr);
		logic [31:0] r;
		ref_mask = mask;
		ref_hdr  = hdr;
		raddr_on = 1'b1;
		for (int i = 0; i < 64; i++) begin
			random_bits(data_lfsr, ROM_W, r);
			cpu_rom_addr = ROM_W'(r);
			next_cycle();
		end
		raddr_on = 1'b0;
	endtask

	task automatic write_nvram(input int addr, input logic [7:0] val);
		nvram_we    = 1'b1;
		nvram_addr  = NV_W'(addr);
		nvram_wdata = val;
		bram_model[addr] = val;
		next_cycle();
		nvram_we = 1'b0;
	endtask

	// Console port read with one cycle of latency
	task automatic read_back_nvram();
		nvram_addr = '0;
		for (int a = 1; a <= NV_BYTES; a++) begin
			next_cycle();
			check(nvram_rdata == bram_model[a-1], $sformatf("nvram byte %0d read %h, expected %h",
				a - 1, nvram_rdata, bram_model[a-1]));
			if (a < NV_BYTES)
				nvram_addr = NV_W'(a);
		end
	endtask

	task automatic run_transfer(input logic save);
		sectors_seen = 0;
		expect_save  = save;
		if (save)
			bk_save = 1'b1;
		else
			bk_load = 1'b1;
		next_cycle();
		bk_save = 1'b0;
		bk_load = 1'b0;
		check(bk_busy, "backup transfer did not start");
		while (bk_busy) begin
			if (!save)
				check(core_reset, "core_reset low while a backup load runs");
			next_cycle();
		end
		check(sectors_seen == sms_pkg::BK_SECTORS,
			$sformatf("host saw %0d sectors, expected %0d", sectors_seen, sms_pkg::BK_SECTORS));
	endtask

	task automatic report_test(input string name);
		test_num++;
		if (errors == errors_mark) begin
			$display("Test %0d %s: passed", test_num, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: failed with %0d errors", test_num, name, errors - errors_mark);
		end
		errors_mark = errors;
	endtask

	// ==================================================
	// Models and compare process
	// ==================================================
	initial begin : rom_model
		logic [31:0] d;
		forever begin
			next_cycle();
			if (!reset && rom_req != rom_ack) begin
				random_bits(delay_lfsr, 2, d); // 0 to 3 cycles of latency
				repeat (d) next_cycle();
				check(rom_waddr == ROM_W'(rom_count), $sformatf("rom_waddr %h, expected %h",
					rom_waddr, rom_count));
				check(rom_wdata == file_data[rom_count % CART_LEN],
					$sformatf("rom_wdata %h at byte %0d, expected %h",
					rom_wdata, rom_count, file_data[rom_count % CART_LEN]));
				rom_count++;
				rom_ack = rom_req;
			end
		end
	end

	initial begin : sector_host
		logic [31:0] d;
		logic save;
		int base;
		forever begin
			next_cycle();
			if (sd_rd || sd_wr) begin
				save = sd_wr;
				check(int'(sd_lba) == sectors_seen, $sformatf("sector %0d requested, expected %0d",
					sd_lba, sectors_seen));
				check(save == expect_save, "sector request of the wrong direction");
				base = (int'(sd_lba) % sms_pkg::BK_SECTORS) * SECTOR;
				sectors_seen++;
				random_bits(delay_lfsr, 2, d);
				repeat (d) next_cycle();
				sd_ack = 1'b1;
				if (save) begin
					sd_buff_addr = '0;
					for (int i = 1; i <= SECTOR; i++) begin
						next_cycle();
						check(sd_buff_din == bram_model[base + i - 1],
							$sformatf("saved byte %0d read %h, expected %h", base + i - 1,
							sd_buff_din, bram_model[base + i - 1]));
						if (i < SECTOR)
							sd_buff_addr = BUF_W'(i);
					end
				end else begin
					for (int i = 0; i < SECTOR; i++) begin
						sd_buff_wr   = 1'b1;
						sd_buff_addr = BUF_W'(i);
						sd_buff_dout = load_data[base + i];
						bram_model[base + i] = load_data[base + i];
						next_cycle();
					end
				end
				sd_ack     = 1'b0; // Falling ack ends the sector
				sd_buff_wr = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (raddr_on)
			check(rom_raddr == expected_raddr(cpu_rom_addr, ref_mask, ref_hdr),
				$sformatf("rom_raddr %h for cpu address %h, expected %h", rom_raddr,
				cpu_rom_addr, expected_raddr(cpu_rom_addr, ref_mask, ref_hdr)));
		if (code_valid)
			valid_count++;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin : main
		logic [31:0] r;
		reset = 1'b1;
		dl_active = 1'b0;
		dl_index = '0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		rom_ack = 1'b0;
		cpu_rom_addr = '0;
		nvram_addr = '0;
		nvram_we = 1'b0;
		nvram_wdata = '0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr = 1'b0;
		sd_buff_dout = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		autosave = 1'b0;
		osd_open = 1'b0;
		expect_save = 1'b0;
		repeat (5) @(posedge clk_sys);
		#2;
		reset = 1'b0;

		check(!dl_wait && !rom_req && !sd_rd && !sd_wr && !code_valid && !bk_busy,
			"outputs not idle after reset");
		while (!ce_vdp)
			next_cycle();
		for (int k = 0; k < 3 * sms_pkg::CE_PERIOD; k++) begin
			check({ce_cpu, ce_vdp, ce_pix, ce_sp} == expected_ce(k),
				$sformatf("enables %b at offset %0d, expected %b",
				{ce_cpu, ce_vdp, ce_pix, ce_sp}, k, expected_ce(k)));
			next_cycle();
		end
		report_test("clock enables");

		fill_file(CART_LEN);
		send_file(8'd1, CART_LEN);
		check(rom_count == CART_LEN, $sformatf("%0d ROM writes, expected %0d", rom_count, CART_LEN));
		sweep_rom_reads(expected_mask(CART_LEN, has_header(CART_LEN)), has_header(CART_LEN));
		check(!gg_mode, "gg_mode set by a normal cart");
		fill_file(GG_LEN);
		send_file(8'd2, GG_LEN);
		check(gg_mode, "gg_mode not set by a handheld cart");
		report_test("cart download");

		fill_file(HDR_LEN);
		send_file(8'd1, HDR_LEN);
		check(rom_count == HDR_LEN, $sformatf("%0d ROM writes, expected %0d", rom_count, HDR_LEN));
		sweep_rom_reads(expected_mask(HDR_LEN, has_header(HDR_LEN)), has_header(HDR_LEN));
		report_test("header cart");

		fill_file(16);
		valid_count = 0;
		send_file(sms_pkg::CHEAT_INDEX, 16);
		check(rom_count == 0, "cheat bytes reached ROM memory");
		check(valid_count == 1, $sformatf("%0d code_valid pulses, expected 1", valid_count));
		check(cheat_code == expected_cheat(), $sformatf("cheat_code %h, expected %h",
			cheat_code, expected_cheat()));
		report_test("cheat record");

		// Writable image mounts during a cart download
		img_mounted = 1'b1;
		fill_file(SMALL_LEN);
		send_file(8'd1, SMALL_LEN);
		img_mounted = 1'b0;
		for (int a = 0; a < NV_BYTES; a++) begin
			random_bits(data_lfsr, 8, r);
			write_nvram(a, r[7:0]);
		end
		run_transfer(1'b1);
		for (int a = 0; a < NV_BYTES; a++) begin
			random_bits(data_lfsr, 8, r);
			load_data[a] = r[7:0];
		end
		run_transfer(1'b0);
		read_back_nvram();
		report_test("backup save and load");

		autosave = 1'b1;
		random_bits(data_lfsr, 8, r);
		write_nvram(5, r[7:0]);
		sectors_seen = 0;
		expect_save  = 1'b1;
		osd_open     = 1'b1; // Menu opens with a write pending
		next_cycle();
		check(sd_wr && sd_lba == 0, "autosave did not request sector 0");
		while (bk_busy)
			next_cycle();
		check(sectors_seen == sms_pkg::BK_SECTORS,
			$sformatf("autosave covered %0d sectors", sectors_seen));
		osd_open = 1'b0;
		fill_file(SMALL_LEN);
		send_file(8'd1, SMALL_LEN); // No image mounted so backup stays disabled
		write_nvram(6, 8'h5a);
		osd_open = 1'b1;
		bk_save  = 1'b1;
		repeat (40) begin
			next_cycle();
			check(!sd_rd && !sd_wr && !bk_busy, "transfer started without a writable save image");
		end
		bk_save  = 1'b0;
		osd_open = 1'b0;
		autosave = 1'b0;
		report_test("autosave");

		$display("Summary: %0d tests, %0d failed, %0d check errors", test_num, failed_tests, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sms_host_top.f ====
source/sms_pkg.sv
source/sms_ifs.sv
source/clock_enable_gen.sv
source/cart_loader.sv
source/cheat_loader.sv
source/backup_ram.sv
source/bk_controller.sv
source/sms_host_top.sv
dv/tb_sms_host.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

LOG=sim.log
TOP=tb_sms_host

verilator --binary --timing --assert -Wno-fatal \
	-f sms_host_top.f \
	--top-module "$TOP" \
	-Mdir obj_dir

# The log decides the verdict, also when the simulator exits with an error
./obj_dir/V"$TOP" 2>&1 | tee "$LOG"

if grep -qx "TEST RESULT: PASS" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
